/* verilog/rv_isa_pkg.sv */
// RV32I encodings and base types
package rv_isa_pkg;

  // ====================
  // Widths and words
  // ====================
  localparam int XLEN = 32;  // RV32 only

  typedef logic [XLEN-1:0] word_t;      // Data or address
  typedef logic [31:0]     instr_t;     // Instruction word
  typedef logic [4:0]      reg_addr_t;  // x0..x31

  // Major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OP_OP     = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111
  } opcode_e;

  // ====================
  // ALU and branches
  // ====================
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B  // LUI
  } alu_op_e;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

/* verilog/rv_pipe_pkg.sv */
// Pipeline payloads and selects
package rv_pipe_pkg;

  // Operand source in execute
  typedef enum logic [1:0] {
    FWD_REG   = 2'b00,  // ID/EX register value
    FWD_WB    = 2'b01,  // MEM/WB writeback data
    FWD_EXMEM = 2'b10   // EX/MEM ALU result
  } fwd_sel_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'b00,
    WB_MEM = 2'b01,
    WB_PC4 = 2'b10  // Link value
  } wb_sel_e;

  // ====================
  // Stage registers
  // ====================
  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::word_t     pc;
    rv_isa_pkg::word_t     rs1_val;
    rv_isa_pkg::word_t     rs2_val;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     imm;
    rv_isa_pkg::opcode_e   opcode;
    logic [2:0]            funct3;
    rv_isa_pkg::alu_op_e   alu_op;
    logic                  alu_src;  // Operand b from imm
    logic                  branch;
    logic                  jump;
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    wb_sel_e               wb_sel;
  } idex_t;

  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::word_t     alu_result;
    rv_isa_pkg::word_t     store_data;
    rv_isa_pkg::word_t     pc_plus4;
    rv_isa_pkg::reg_addr_t rd;
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    wb_sel_e               wb_sel;
  } exmem_t;

  // One register write leaving MEM/WB
  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     data;
  } retire_t;

endpackage

/* verilog/hazard_if.sv */
// Hazard and forwarding signals
interface hazard_if;

  // From decode
  rv_isa_pkg::reg_addr_t id_rs1, id_rs2;
  logic                  id_use_rs1, id_use_rs2;  // Instruction reads the source
  // From execute
  rv_isa_pkg::reg_addr_t ex_rs1, ex_rs2, ex_rd;
  logic                  ex_mem_read;
  logic                  take_branch;
  // From memory
  rv_isa_pkg::reg_addr_t mem_rd, wb_rd;
  logic                  mem_reg_write, wb_reg_write;
  // From control
  logic                  stall, flush, bubble;
  rv_pipe_pkg::fwd_sel_e forward_a, forward_b;

  modport fetch (input stall, flush, take_branch);
  modport decode (output id_rs1, id_rs2, id_use_rs1, id_use_rs2, input bubble);
  modport execute (output ex_rs1, ex_rs2, ex_rd, ex_mem_read, take_branch,
                   input forward_a, forward_b);
  modport memory (output mem_rd, mem_reg_write, wb_rd, wb_reg_write);
  modport control (input id_rs1, id_rs2, id_use_rs1, id_use_rs2,
                   input ex_rs1, ex_rs2, ex_rd, ex_mem_read, take_branch,
                   input mem_rd, mem_reg_write, wb_rd, wb_reg_write,
                   output stall, flush, bubble, forward_a, forward_b);

endinterface

/* verilog/pipeline_control.sv */
// Hazard detection and forwarding
module pipeline_control (
  hazard_if.control hz
);

  logic load_use;

  // Youngest writing producer wins
  function automatic rv_pipe_pkg::fwd_sel_e fwd_pick(
    input rv_isa_pkg::reg_addr_t rs,
    input rv_isa_pkg::reg_addr_t mem_rd,
    input logic                  mem_we,
    input rv_isa_pkg::reg_addr_t wb_rd,
    input logic                  wb_we
  );
    if (mem_we && mem_rd != '0 && mem_rd == rs) begin
      return rv_pipe_pkg::FWD_EXMEM;
    end else if (wb_we && wb_rd != '0 && wb_rd == rs) begin
      return rv_pipe_pkg::FWD_WB;
    end
    return rv_pipe_pkg::FWD_REG;
  endfunction

  // ====================
  // Load-use
  // ====================
  // Load in EX, its rd needed by the instruction in ID
  assign load_use = hz.ex_mem_read && (hz.ex_rd != '0) &&
                    ((hz.id_use_rs1 && hz.id_rs1 == hz.ex_rd) ||
                     (hz.id_use_rs2 && hz.id_rs2 == hz.ex_rd));

  assign hz.stall  = load_use;                     // Hold pc and IF/ID
  assign hz.flush  = hz.take_branch;               // Drop IF/ID
  assign hz.bubble = load_use | hz.take_branch;    // Empty ID/EX

  // ====================
  // Forward selects
  // ====================
  assign hz.forward_a = fwd_pick(hz.ex_rs1, hz.mem_rd, hz.mem_reg_write,
                                 hz.wb_rd, hz.wb_reg_write);
  assign hz.forward_b = fwd_pick(hz.ex_rs2, hz.mem_rd, hz.mem_reg_write,
                                 hz.wb_rd, hz.wb_reg_write);

endmodule

/* verilog/fetch_stage.sv */
// Instruction fetch
module fetch_stage #(
  parameter int IMEM_WORDS = 256
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               imem_we,
  input  rv_isa_pkg::word_t  imem_addr,
  input  rv_isa_pkg::instr_t imem_wdata,
  input  rv_isa_pkg::word_t  redirect_target,
  hazard_if.fetch            hz,
  output rv_isa_pkg::word_t  ifid_pc,
  output rv_isa_pkg::instr_t ifid_instr,
  output logic               ifid_valid
);

  localparam int IW = $clog2(IMEM_WORDS);  // Word index bits

  rv_isa_pkg::instr_t imem [IMEM_WORDS];
  rv_isa_pkg::word_t  pc, pc_next;
  rv_isa_pkg::instr_t instr;

  // Program load port
  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_addr[IW+1:2]] <= imem_wdata;
  end

  assign instr = imem[pc[IW+1:2]];  // Async read

  // Redirect beats stall
  always_comb begin
    if (hz.take_branch)  pc_next = redirect_target;
    else if (hz.stall)   pc_next = pc;
    else                 pc_next = pc + 32'd4;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) pc <= '0;
    else          pc <= pc_next;
  end

  // ====================
  // IF/ID register
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)       ifid_valid <= 1'b0;
    else if (hz.flush)  ifid_valid <= 1'b0;  // Wrong path
    else if (!hz.stall) ifid_valid <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!hz.stall) begin
      ifid_pc    <= pc;
      ifid_instr <= instr;
    end
  end

endmodule

/* verilog/decode_stage.sv */
// Instruction decode and register file
module decode_stage (
  input  logic                 clk,
  input  logic                 reset_n,
  input  rv_isa_pkg::word_t    ifid_pc,
  input  rv_isa_pkg::instr_t   ifid_instr,
  input  logic                 ifid_valid,
  input  rv_pipe_pkg::retire_t wb,
  hazard_if.decode             hz,
  output rv_pipe_pkg::idex_t   idex
);

  rv_isa_pkg::word_t     regs [32];
  rv_isa_pkg::opcode_e   opcode;
  rv_isa_pkg::reg_addr_t rs1, rs2;
  logic [2:0]            funct3;
  rv_isa_pkg::word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
  logic                  live;  // Real instruction entering ID/EX
  rv_pipe_pkg::idex_t    d;

  // funct3 plus the alternate bit (sub, sra)
  function automatic rv_isa_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      3'b001:  return rv_isa_pkg::ALU_SLL;
      3'b010:  return rv_isa_pkg::ALU_SLT;
      3'b011:  return rv_isa_pkg::ALU_SLTU;
      3'b100:  return rv_isa_pkg::ALU_XOR;
      3'b101:  return alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'b110:  return rv_isa_pkg::ALU_OR;
      default: return rv_isa_pkg::ALU_AND;
    endcase
  endfunction

  // x0 reads zero, same-cycle writeback bypasses the array
  function automatic rv_isa_pkg::word_t rf_read(input rv_isa_pkg::reg_addr_t a,
                                                input rv_isa_pkg::word_t stored,
                                                input rv_pipe_pkg::retire_t w);
    if (a == '0)                return '0;
    else if (w.valid && w.rd == a) return w.data;
    return stored;
  endfunction

  // ====================
  // Fields
  // ====================
  assign opcode = rv_isa_pkg::opcode_e'(ifid_instr[6:0]);
  assign rs1    = ifid_instr[19:15];
  assign rs2    = ifid_instr[24:20];
  assign funct3 = ifid_instr[14:12];
  assign imm_i  = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
  assign imm_s  = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
  assign imm_b  = {{19{ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
                   ifid_instr[30:25], ifid_instr[11:8], 1'b0};
  assign imm_u  = {ifid_instr[31:12], 12'b0};
  assign imm_j  = {{11{ifid_instr[31]}}, ifid_instr[31], ifid_instr[19:12],
                   ifid_instr[20], ifid_instr[30:21], 1'b0};
  assign live   = ifid_valid & ~hz.bubble;

  assign hz.id_rs1 = rs1;
  assign hz.id_rs2 = rs2;

  // Register file, written from MEM/WB
  always_ff @(posedge clk) begin
    if (wb.valid) regs[wb.rd] <= wb.data;
  end

  // ====================
  // Control decode
  // ====================
  always_comb begin
    d         = '0;
    d.valid   = live;
    d.pc      = ifid_pc;
    d.rs1_val = rf_read(rs1, regs[rs1], wb);
    d.rs2_val = rf_read(rs2, regs[rs2], wb);
    d.rs1     = rs1;
    d.rs2     = rs2;
    d.rd      = ifid_instr[11:7];
    d.opcode  = opcode;
    d.funct3  = funct3;
    d.alu_op  = rv_isa_pkg::ALU_ADD;
    d.alu_src = 1'b1;
    d.imm     = imm_i;
    d.wb_sel  = rv_pipe_pkg::WB_ALU;
    hz.id_use_rs1 = 1'b0;
    hz.id_use_rs2 = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_OP: begin
        d.alu_op = alu_decode(funct3, ifid_instr[30]);
        d.alu_src = 1'b0;
        d.reg_write = live;
        hz.id_use_rs1 = 1'b1;
        hz.id_use_rs2 = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        d.alu_op = alu_decode(funct3, ifid_instr[30] && funct3 == 3'b101);  // srai only
        d.reg_write = live;
        hz.id_use_rs1 = 1'b1;
      end
      rv_isa_pkg::OP_LOAD: begin
        d.mem_read = live;
        d.reg_write = live;
        d.wb_sel = rv_pipe_pkg::WB_MEM;
        hz.id_use_rs1 = 1'b1;
      end
      rv_isa_pkg::OP_STORE: begin
        d.mem_write = live;
        d.imm = imm_s;
        hz.id_use_rs1 = 1'b1;
        hz.id_use_rs2 = 1'b1;
      end
      rv_isa_pkg::OP_BRANCH: begin
        d.branch = live;
        d.alu_src = 1'b0;
        d.imm = imm_b;
        hz.id_use_rs1 = 1'b1;
        hz.id_use_rs2 = 1'b1;
      end
      rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: begin
        d.jump = live;
        d.reg_write = live;
        d.wb_sel = rv_pipe_pkg::WB_PC4;  // Link
        d.imm = (opcode == rv_isa_pkg::OP_JAL) ? imm_j : imm_i;
        hz.id_use_rs1 = (opcode == rv_isa_pkg::OP_JALR);
      end
      rv_isa_pkg::OP_LUI: begin
        d.alu_op = rv_isa_pkg::ALU_PASS_B;
        d.imm = imm_u;
        d.reg_write = live;
      end
      rv_isa_pkg::OP_AUIPC: begin
        d.imm = imm_u;  // pc + imm in execute
        d.reg_write = live;
      end
      default: ;  // Unknown opcode, no side effects
    endcase
  end

  // ID/EX register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) idex <= '0;
    else          idex <= d;
  end

endmodule

/* verilog/execute_stage.sv */
// Execute with forwarding and branch resolve
module execute_stage (
  input  logic                 clk,
  input  logic                 reset_n,
  input  rv_pipe_pkg::idex_t   idex,
  input  rv_isa_pkg::word_t    exmem_fwd,
  input  rv_pipe_pkg::retire_t wb,
  hazard_if.execute            hz,
  output rv_isa_pkg::word_t    redirect_target,
  output rv_pipe_pkg::exmem_t  exmem
);

  rv_isa_pkg::word_t rs1_fwd, rs2_fwd;  // Forwarded register values
  rv_isa_pkg::word_t op_a, op_b, alu_y;
  logic              cond;              // Branch compare holds

  function automatic rv_isa_pkg::word_t fwd_mux(input rv_pipe_pkg::fwd_sel_e sel,
                                                input rv_isa_pkg::word_t reg_val,
                                                input rv_isa_pkg::word_t mem_val,
                                                input rv_isa_pkg::word_t wb_val);
    case (sel)
      rv_pipe_pkg::FWD_EXMEM: return mem_val;
      rv_pipe_pkg::FWD_WB:    return wb_val;
      default:                return reg_val;
    endcase
  endfunction

  assign hz.ex_rs1      = idex.rs1;
  assign hz.ex_rs2      = idex.rs2;
  assign hz.ex_rd       = idex.rd;
  assign hz.ex_mem_read = idex.valid & idex.mem_read;

  // ====================
  // Operands and ALU
  // ====================
  assign rs1_fwd = fwd_mux(hz.forward_a, idex.rs1_val, exmem_fwd, wb.data);
  assign rs2_fwd = fwd_mux(hz.forward_b, idex.rs2_val, exmem_fwd, wb.data);
  assign op_a    = (idex.opcode == rv_isa_pkg::OP_AUIPC) ? idex.pc : rs1_fwd;
  assign op_b    = idex.alu_src ? idex.imm : rs2_fwd;

  always_comb begin
    case (idex.alu_op)
      rv_isa_pkg::ALU_ADD:    alu_y = op_a + op_b;
      rv_isa_pkg::ALU_SUB:    alu_y = op_a - op_b;
      rv_isa_pkg::ALU_SLL:    alu_y = op_a << op_b[4:0];
      rv_isa_pkg::ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_isa_pkg::ALU_SLTU:   alu_y = {31'b0, op_a < op_b};
      rv_isa_pkg::ALU_XOR:    alu_y = op_a ^ op_b;
      rv_isa_pkg::ALU_SRL:    alu_y = op_a >> op_b[4:0];
      rv_isa_pkg::ALU_SRA:    alu_y = $signed(op_a) >>> op_b[4:0];
      rv_isa_pkg::ALU_OR:     alu_y = op_a | op_b;
      rv_isa_pkg::ALU_AND:    alu_y = op_a & op_b;
      rv_isa_pkg::ALU_PASS_B: alu_y = op_b;  // LUI
      default:                alu_y = '0;
    endcase
  end

  // ====================
  // Branch resolve
  // ====================
  always_comb begin
    case (idex.funct3)
      rv_isa_pkg::F3_BEQ:  cond = (rs1_fwd == rs2_fwd);
      rv_isa_pkg::F3_BNE:  cond = (rs1_fwd != rs2_fwd);
      rv_isa_pkg::F3_BLT:  cond = ($signed(rs1_fwd) < $signed(rs2_fwd));
      rv_isa_pkg::F3_BGE:  cond = ($signed(rs1_fwd) >= $signed(rs2_fwd));
      rv_isa_pkg::F3_BLTU: cond = (rs1_fwd < rs2_fwd);
      rv_isa_pkg::F3_BGEU: cond = (rs1_fwd >= rs2_fwd);
      default:             cond = 1'b0;
    endcase
  end

  assign hz.take_branch = idex.valid & (idex.jump | (idex.branch & cond));
  assign redirect_target = (idex.opcode == rv_isa_pkg::OP_JALR) ?
                           ((rs1_fwd + idex.imm) & ~32'd1) :  // JALR clears bit 0
                           (idex.pc + idex.imm);

  // EX/MEM register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      exmem <= '0;
    end else begin
      exmem.valid      <= idex.valid;
      exmem.alu_result <= alu_y;
      exmem.store_data <= rs2_fwd;
      exmem.pc_plus4   <= idex.pc + 32'd4;
      exmem.rd         <= idex.rd;
      exmem.mem_read   <= idex.mem_read;
      exmem.mem_write  <= idex.mem_write;
      exmem.reg_write  <= idex.reg_write;
      exmem.wb_sel     <= idex.wb_sel;
    end
  end

endmodule

/* verilog/memory_stage.sv */
// Data memory and writeback
module memory_stage #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  rv_pipe_pkg::exmem_t  exmem,
  hazard_if.memory             hz,
  output rv_isa_pkg::word_t    exmem_fwd,
  output rv_pipe_pkg::retire_t wb
);

  localparam int DW = $clog2(DMEM_WORDS);

  rv_isa_pkg::word_t   dmem [DMEM_WORDS];
  rv_isa_pkg::word_t   load_data;
  // MEM/WB register
  logic                  mw_reg_write;  // Valid write
  rv_isa_pkg::reg_addr_t mw_rd;
  rv_pipe_pkg::wb_sel_e  mw_wb_sel;
  rv_isa_pkg::word_t     mw_alu, mw_load, mw_pc4;

  // Word store on the edge
  always_ff @(posedge clk) begin
    if (exmem.valid && exmem.mem_write) dmem[exmem.alu_result[DW+1:2]] <= exmem.store_data;
  end

  assign load_data = exmem.mem_read ? dmem[exmem.alu_result[DW+1:2]] : '0;
  assign exmem_fwd = exmem.alu_result;

  // ====================
  // MEM/WB register
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mw_reg_write <= 1'b0;
      mw_rd        <= '0;
      mw_wb_sel    <= rv_pipe_pkg::WB_ALU;
    end else begin
      mw_reg_write <= exmem.valid & exmem.reg_write;
      mw_rd        <= exmem.rd;
      mw_wb_sel    <= exmem.wb_sel;
    end
  end

  always_ff @(posedge clk) begin
    mw_alu  <= exmem.alu_result;
    mw_load <= load_data;
    mw_pc4  <= exmem.pc_plus4;
  end

  // Writeback mux
  always_comb begin
    case (mw_wb_sel)
      rv_pipe_pkg::WB_MEM: wb.data = mw_load;
      rv_pipe_pkg::WB_PC4: wb.data = mw_pc4;
      default:             wb.data = mw_alu;
    endcase
  end
  assign wb.rd    = mw_rd;
  assign wb.valid = mw_reg_write & (mw_rd != '0);  // x0 never retires

  assign hz.mem_rd        = exmem.rd;
  assign hz.mem_reg_write = exmem.valid & exmem.reg_write;
  assign hz.wb_rd         = mw_rd;
  assign hz.wb_reg_write  = mw_reg_write;

endmodule

/* verilog/rv_core.sv */
// Five-stage RV32I core
module rv_core #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  imem_we,
  input  rv_isa_pkg::word_t     imem_addr,
  input  rv_isa_pkg::instr_t    imem_wdata,
  output logic                  retire_valid,
  output rv_isa_pkg::reg_addr_t retire_rd,
  output rv_isa_pkg::word_t     retire_data
);

  hazard_if hz ();

  rv_isa_pkg::word_t    ifid_pc, redirect_target, exmem_fwd;
  rv_isa_pkg::instr_t   ifid_instr;
  logic                 ifid_valid;
  rv_pipe_pkg::idex_t   idex;
  rv_pipe_pkg::exmem_t  exmem;
  rv_pipe_pkg::retire_t wb;  // Register write out of MEM/WB

  // ====================
  // Stages
  // ====================
  fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) i_fetch (
    .clk, .reset_n, .imem_we, .imem_addr, .imem_wdata, .redirect_target,
    .hz(hz.fetch), .ifid_pc, .ifid_instr, .ifid_valid
  );

  decode_stage i_decode (
    .clk, .reset_n, .ifid_pc, .ifid_instr, .ifid_valid, .wb, .hz(hz.decode), .idex
  );

  execute_stage i_execute (
    .clk, .reset_n, .idex, .exmem_fwd, .wb, .hz(hz.execute), .redirect_target, .exmem
  );

  memory_stage #(.DMEM_WORDS(DMEM_WORDS)) i_memory (
    .clk, .reset_n, .exmem, .hz(hz.memory), .exmem_fwd, .wb
  );

  pipeline_control i_control (.hz(hz.control));

  assign retire_valid = wb.valid;
  assign retire_rd    = wb.rd;
  assign retire_data  = wb.data;

endmodule

/* bench/retire_checker.sv */
// Retire port checker
module retire_checker (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  retire_valid,
  input  rv_isa_pkg::reg_addr_t retire_rd,
  input  rv_isa_pkg::word_t     retire_data,
  output logic                  all_seen,
  output int                    error_count
);
  timeunit 1ns;
  timeprecision 100ps;

  // Expected writes in program order
  string                 test_name [$];
  int                    test_len [$];    // Writes per test
  int                    test_errs [$];
  rv_isa_pkg::reg_addr_t exp_rd [$];
  rv_isa_pkg::word_t     exp_data [$];
  int                    exp_test [$];    // Owning test of each entry
  int                    next_idx = 0;
  int                    checked = 0;
  int                    errors = 0;
  int                    tests_passed = 0;
  int                    tests_failed = 0;
  logic                  seen_all = 1'b0;

  assign all_seen    = seen_all;
  assign error_count = errors;

  // ====================
  // Expected list
  // ====================
  task automatic add_test(input string name);
    test_name.push_back(name);
    test_len.push_back(0);
    test_errs.push_back(0);
  endtask

  task automatic add_expect(input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::word_t data);
    int t;
    if (test_name.size() == 0) add_test("unnamed");  // E line before any T line
    t = test_name.size() - 1;
    exp_rd.push_back(rd);
    exp_data.push_back(data);
    exp_test.push_back(t);
    test_len[t] = test_len[t] + 1;
  endtask

  task automatic report_test(input int t);
    if (test_errs[t] == 0) begin
      $display("Test %s: passed, %0d writes", test_name[t], test_len[t]);
      tests_passed++;
    end else begin
      $display("Test %s: failed, %0d errors", test_name[t], test_errs[t]);
      tests_failed++;
    end
  endtask

  // ====================
  // Compare
  // ====================
  task automatic compare_retire();
    int t;
    int errs;
    errs = 0;
    checked++;
    if (next_idx >= exp_rd.size()) begin
      $display("Unexpected write to x%0d with data 0x%08h after the last expected write",
               retire_rd, retire_data);
      errors++;
      return;
    end
    t = exp_test[next_idx];
    if (retire_rd !== exp_rd[next_idx]) begin
      $display("Mismatch retire_rd in %s: expected 0x%02h, got 0x%02h",
               test_name[t], exp_rd[next_idx], retire_rd);
      errs++;
    end
    if (retire_data !== exp_data[next_idx]) begin
      $display("Mismatch retire_data in %s: expected 0x%08h, got 0x%08h",
               test_name[t], exp_data[next_idx], retire_data);
      errs++;
    end
    errors       = errors + errs;
    test_errs[t] = test_errs[t] + errs;
    next_idx++;
    if (next_idx == exp_rd.size() || exp_test[next_idx] != t) report_test(t);  // Last of test
    if (next_idx == exp_rd.size()) seen_all = 1'b1;
  endtask

  // Retire outputs settle after the rising edge
  always @(negedge clk) begin
    if (!reset_n) begin
      if (retire_valid !== 1'b0) begin
        $display("retire_valid is not low during reset at %0t", $time);
        errors++;
      end
    end else if (retire_valid !== 1'b0) begin
      compare_retire();
    end
  end

  task automatic report_timeout(input int cyc);
    if (next_idx < exp_rd.size()) begin
      $display("Timeout after %0d cycles: test %s never completed, %0d writes missing",
               cyc, test_name[exp_test[next_idx]], exp_rd.size() - next_idx);
    end else begin
      $display("Timeout after %0d cycles", cyc);
    end
  endtask

  task automatic report_counts();
    $display("Tests passed %0d, failed %0d, incomplete %0d; retires %0d; errors %0d",
             tests_passed, tests_failed, test_name.size() - tests_passed - tests_failed,
             checked, errors);
  endtask

endmodule

/* bench/tb_rv_core.sv */
// RV32I core testbench
module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam string PATTERN_FILE = "bench/rv_core_patterns.txt";

  logic                  clk;
  logic                  reset_n;
  logic                  imem_we;
  rv_isa_pkg::word_t     imem_addr;
  rv_isa_pkg::instr_t    imem_wdata;
  logic                  retire_valid;
  rv_isa_pkg::reg_addr_t retire_rd;
  rv_isa_pkg::word_t     retire_data;
  logic                  all_seen;     // Every expected write retired
  int                    error_count;

  rv_isa_pkg::word_t  prog_addr [$];  // Program image
  rv_isa_pkg::instr_t prog_word [$];
  int                 cycles;
  int                 limit;          // Timeout in cycles
  logic               timed_out;
  logic               file_ok;

  rv_core #(.IMEM_WORDS(256), .DMEM_WORDS(256)) i_rv_core (
    .clk, .reset_n, .imem_we, .imem_addr, .imem_wdata,
    .retire_valid, .retire_rd, .retire_data
  );

  retire_checker i_checker (
    .clk, .reset_n, .retire_valid, .retire_rd, .retire_data, .all_seen, .error_count
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================
  // Pattern file
  // ====================
  // Program words stay here and expected writes go to the checker
  task automatic read_patterns(output logic ok);
    int          fd;
    int          last;
    int          n;
    string       line;
    string       rest;
    logic [31:0] a, b;
    ok = 1'b0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) return;
    ok = 1'b1;
    while ($fgets(line, fd) != 0) begin
      last = line.len() - 1;
      if (last >= 0 && line.getc(last) == 8'h0a) last--;  // Drop newline
      if (last < 2) continue;                           // Blank line
      rest = line.substr(2, last);
      case (line.getc(0))
        "T": i_checker.add_test(rest);
        "P", "E": begin
          n = $sscanf(rest, "%h %h", a, b);
          if (n != 2) begin
            $display("Malformed pattern line: %s", line.substr(0, last));
            ok = 1'b0;
          end else if (line.getc(0) == "P") begin
            prog_addr.push_back(a);
            prog_word.push_back(b);
          end else begin
            i_checker.add_expect(a[4:0], b);
          end
        end
        default: ;  // Comment
      endcase
    end
    $fclose(fd);
  endtask

  // Load through the imem port while the core sits in reset
  task automatic load_program();
    foreach (prog_word[i]) begin
      @(posedge clk);
      #1;
      imem_we    = 1'b1;
      imem_addr  = prog_addr[i];
      imem_wdata = prog_word[i];
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
    repeat (4) @(posedge clk);  // Four more reset cycles
    #1;
    reset_n = 1'b1;
  endtask

  // Until every expected write retired or the limit is hit
  task automatic run_program();
    limit = 20 * prog_word.size() + 100;
    while (!all_seen && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!all_seen) begin
      timed_out = 1'b1;
      i_checker.report_timeout(cycles);
    end else begin
      repeat (10) @(posedge clk);  // Catch stray retires from the end loop
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    reset_n    = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    timed_out  = 1'b0;
    cycles     = 0;
    read_patterns(file_ok);
    if (!file_ok) begin
      $display("Could not read a valid program from %s", PATTERN_FILE);
    end else begin
      load_program();
      run_program();
      i_checker.report_counts();
    end
    if (!file_ok || timed_out || error_count != 0) begin
      $display("=== FAIL ===");
    end else begin
      $display("=== PASS ===");
    end
    $finish;
  end

endmodule

/* bench/rv_core_patterns.txt */
# T <test name> | P <byte address> <instruction word> | E <rd> <value>, all hex
# E lines list the register writes of the test in program order
T alu_imm
P 00 00500093
P 04 FFD00113
P 08 002081B3
P 0C 40208233
P 10 401152B3
P 14 00115333
P 18 0020B3B3
P 1C 0020A433
P 20 0F00C493
P 24 00409513
P 28 123455B7
P 2C 00001617
P 30 00A4F6B3
E 01 00000005
E 02 FFFFFFFD
E 03 00000002
E 04 00000008
E 05 FFFFFFFF
E 06 07FFFFFF
E 07 00000001
E 08 00000000
E 09 000000F5
E 0A 00000050
E 0B 12345000
E 0C 0000102C
E 0D 00000050
T forward_bypass
P 34 00700713
P 38 00170793
P 3C 00F70833
P 40 010708B3
E 0E 00000007
E 0F 00000008
E 10 0000000F
E 11 00000016
T x0_write
P 44 00908013
P 48 00100933
E 12 00000005
T load_store
P 4C 04000993
P 50 00B9A223
P 54 0049AA03
E 13 00000040
E 14 12345000
T load_use
P 58 001A0A93
E 15 12345001
T branch_jump
P 5C 01208663
P 60 00100B13
P 64 00100B93
P 68 01209463
P 6C 00200C13
P 70 00114463
P 74 00300C93
P 78 00116463
P 7C 00C00D6F
P 80 00400D93
P 84 00500E13
P 88 015D0EE7
P 8C 00600F13
P 90 00700F93
P 94 018E8FB3
P 98 0000006F
E 18 00000002
E 1A 00000080
E 1D 0000008C
E 1F 0000008E

/* verilog.f */
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/hazard_if.sv
verilog/pipeline_control.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/rv_core.sv
bench/retire_checker.sv
bench/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_rv_core -o tb_rv_core
./obj_dir/tb_rv_core > sim.log
cat sim.log
if grep -qF "=== FAIL ===" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished, no failure reported"
